/* include/rvOpcodes.svh */
// RV32I opcode, funct3 and funct7 code macros
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

// major opcodes
`define RvOpLoad	7'b0000011
`define RvOpLoadFp	7'b0000111
`define RvOpMiscMem	7'b0001111
`define RvOpImm		7'b0010011
`define RvOpAuipc	7'b0010111
`define RvOpStore	7'b0100011
`define RvOpStoreFp	7'b0100111
`define RvOpAmo		7'b0101111
`define RvOpR		7'b0110011
`define RvOpLui		7'b0110111
`define RvOpMadd	7'b1000011
`define RvOpMsub	7'b1000111
`define RvOpNmsub	7'b1001011
`define RvOpNmadd	7'b1001111
`define RvOpOpFp	7'b1010011
`define RvOpBranch	7'b1100011
`define RvOpJalr	7'b1100111
`define RvOpJal		7'b1101111
`define RvOpSystem	7'b1110011

// funct3 for loads and stores
`define RvF3Byte	3'b000
`define RvF3Half	3'b001
`define RvF3Word	3'b010
`define RvF3Ubyte	3'b100
`define RvF3Uhalf	3'b101

// funct3 for branches
`define RvF3Beq		3'b000
`define RvF3Bne		3'b001
`define RvF3Blt		3'b100
`define RvF3Bge		3'b101
`define RvF3Bltu	3'b110
`define RvF3Bgeu	3'b111

// funct3 for OP and OP-IMM
`define RvF3AddSub	3'b000
`define RvF3Sll		3'b001
`define RvF3Slt		3'b010
`define RvF3Sltu	3'b011
`define RvF3Xor		3'b100
`define RvF3SraSrl	3'b101
`define RvF3Or		3'b110
`define RvF3And		3'b111

// funct7
`define RvF7Base	7'b0000000
`define RvF7Alt		7'b0100000

`endif

/* hdl/rvPkg.sv */
// RV32I instruction formats, decoded entry, command and result record types
`default_nettype none

package rvPkg;

	localparam int Xlen = 32;

	typedef logic [4:0] RegAddr_t;

	// instruction formats, msb first
	typedef struct packed {
		logic [6:0] funct7;
		RegAddr_t rs2;
		RegAddr_t rs1;
		logic [2:0] funct3;
		RegAddr_t rd;
		logic [6:0] opcode;
	} RvRtype_t;

	typedef struct packed {
		logic [11:0] imm;
		RegAddr_t rs1;
		logic [2:0] funct3;
		RegAddr_t rd;
		logic [6:0] opcode;
	} RvItype_t;

	typedef struct packed {
		logic [6:0] immHi;
		RegAddr_t rs2;
		RegAddr_t rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} RvStype_t;

	// imm bits 12, 10:5, 4:1 and 11
	typedef struct packed {
		logic sign;
		logic [5:0] immHi;
		RegAddr_t rs2;
		RegAddr_t rs1;
		logic [2:0] funct3;
		logic [3:0] immLo;
		logic imm11;
		logic [6:0] opcode;
	} RvBtype_t;

	typedef struct packed {
		logic [19:0] imm;
		RegAddr_t rd;
		logic [6:0] opcode;
	} RvUtype_t;

	// imm bits 20, 10:1, 11 and 19:12
	typedef struct packed {
		logic sign;
		logic [9:0] immLo;
		logic imm11;
		logic [7:0] immHi;
		RegAddr_t rd;
		logic [6:0] opcode;
	} RvJtype_t;

	typedef union packed {
		RvRtype_t r;
		RvItype_t i;
		RvStype_t s;
		RvBtype_t b;
		RvUtype_t u;
		RvJtype_t j;
	} RvInst_t;

	typedef enum logic [1:0] {RegNone, RegGpr, RegPc, RegImm} RegType_t;

	typedef struct packed {
		RegType_t regType;
		RegAddr_t addr;
	} Operand_t;

	// already extended to full width
	typedef logic [Xlen-1:0] ImmData_t;

	typedef enum logic [1:0] {UnitNop, UnitAlu, UnitMem} ExeUnit_t;
	typedef enum logic [1:0] {AluAdd, AluComp, AluShift, AluLogic} AluOp_t;
	typedef enum logic [1:0] {LogicXor, LogicOr, LogicAnd} LogicSel_t;

	typedef struct packed {
		logic sub;
		logic right;
		logic arith;
		logic isUnsigned;
		logic lessThan;
		logic negate;
		logic branch;
		logic jump;
		LogicSel_t logicSel;
	} AluSubOp_t;

	typedef struct packed {
		AluOp_t op;
		AluSubOp_t subOp;
	} AluCmd_t;

	typedef enum logic {MemLoad, MemStore} MemOp_t;
	typedef enum logic [1:0] {MemByte, MemHalf, MemWord} MemSize_t;

	typedef struct packed {
		MemOp_t op;
		MemSize_t size;
		logic isUnsigned;
	} MemCmd_t;

	// unit picks which half is meaningful
	typedef struct packed {
		AluCmd_t alu;
		MemCmd_t mem;
	} Command_t;

	typedef struct packed {
		logic [Xlen-1:0] pc;
		Operand_t rs1;
		Operand_t rs2;
		Operand_t rd;
		ImmData_t imm;
		ExeUnit_t unit;
		Command_t command;
		logic invalid;
	} DecEntry_t;

	typedef struct packed {
		logic [Xlen-1:0] pc;
		RegAddr_t rd;
		logic writeRd;
		logic [Xlen-1:0] value;
		logic [Xlen-1:0] target;
		logic taken;
		logic memValid;
		MemCmd_t memCmd;
		logic [Xlen-1:0] memAddr;
		logic [Xlen-1:0] storeData;
		logic invalid;
	} Result_t;

endpackage

`default_nettype wire

/* hdl/instDecoder.sv */
// instruction decoder with input handshake and decoded-entry register
`timescale 1ns/10ps
`default_nettype none
`include "rvOpcodes.svh"

module instDecoder import rvPkg::*; (
	input logic clk,
	input logic reset_,
	input logic inValid,
	output logic inReady,
	input logic [Xlen-1:0] inPc,
	input RvInst_t inInst,
	output logic decValid,
	input logic decReady,
	output DecEntry_t decEntry
);

	DecEntry_t dec;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic badCode;

	function automatic Operand_t gpr(input RegAddr_t addr);
		return '{regType: RegGpr, addr: addr};
	endfunction

	// opcode and funct3 sit at the same place in every format that has them
	assign opcode = inInst.r.opcode;
	assign funct3 = inInst.r.funct3;
	assign funct7 = inInst.r.funct7;

	// empty, or the held entry leaves this cycle
	assign inReady = !decValid || decReady;

	always_comb begin
		dec = '0;
		dec.pc = inPc;
		badCode = 1'b0;
		case (opcode)
			`RvOpLoad: begin
				dec.unit = UnitMem;
				dec.command.mem.op = MemLoad;
				dec.rs1 = gpr(inInst.i.rs1);
				dec.rd = gpr(inInst.i.rd);
				dec.imm = {{20{inInst.i.imm[11]}}, inInst.i.imm};
				case (funct3)
					`RvF3Byte, `RvF3Half, `RvF3Word, `RvF3Ubyte, `RvF3Uhalf: begin
						dec.command.mem.size = MemSize_t'(funct3[1:0]);
						dec.command.mem.isUnsigned = funct3[2];
					end
					default: badCode = 1'b1;
				endcase
			end
			`RvOpStore: begin
				dec.unit = UnitMem;
				dec.command.mem.op = MemStore;
				dec.rs1 = gpr(inInst.s.rs1);
				dec.rs2 = gpr(inInst.s.rs2);
				dec.imm = {{20{inInst.s.immHi[6]}}, inInst.s.immHi, inInst.s.immLo};
				case (funct3)
					`RvF3Byte, `RvF3Half, `RvF3Word: begin
						dec.command.mem.size = MemSize_t'(funct3[1:0]);
					end
					default: badCode = 1'b1;
				endcase
			end
			`RvOpBranch: begin
				dec.unit = UnitAlu;
				dec.command.alu.op = AluComp;
				dec.command.alu.subOp.branch = 1'b1;
				dec.rs1 = gpr(inInst.b.rs1);
				dec.rs2 = gpr(inInst.b.rs2);
				dec.imm = {{19{inInst.b.sign}}, inInst.b.sign, inInst.b.imm11,
					inInst.b.immHi, inInst.b.immLo, 1'b0};
				case (funct3)
					`RvF3Beq, `RvF3Bne, `RvF3Blt, `RvF3Bge, `RvF3Bltu, `RvF3Bgeu: begin
						// bit 2 picks less-than, bit 1 unsigned, bit 0 inverts
						dec.command.alu.subOp.lessThan = funct3[2];
						dec.command.alu.subOp.isUnsigned = funct3[1];
						dec.command.alu.subOp.negate = funct3[0];
					end
					default: badCode = 1'b1;
				endcase
			end
			`RvOpJalr: begin
				dec.unit = UnitAlu;
				dec.command.alu.subOp.jump = 1'b1;
				dec.rs1 = gpr(inInst.i.rs1);
				dec.rs2.regType = RegImm;
				dec.rd = gpr(inInst.i.rd);
				dec.imm = {{20{inInst.i.imm[11]}}, inInst.i.imm};
				badCode = (funct3 != 3'b000);
			end
			`RvOpJal: begin
				dec.unit = UnitAlu;
				dec.command.alu.subOp.jump = 1'b1;
				dec.rs1.regType = RegPc;
				dec.rs2.regType = RegImm;
				dec.rd = gpr(inInst.j.rd);
				dec.imm = {{11{inInst.j.sign}}, inInst.j.sign, inInst.j.immHi,
					inInst.j.imm11, inInst.j.immLo, 1'b0};
			end
			`RvOpImm: begin
				dec.unit = UnitAlu;
				dec.rs1 = gpr(inInst.i.rs1);
				dec.rs2.regType = RegImm;
				dec.rd = gpr(inInst.i.rd);
				case (funct3)
					`RvF3AddSub: dec.imm = {{20{inInst.i.imm[11]}}, inInst.i.imm};
					`RvF3Sll: begin
						dec.command.alu.op = AluShift;
						// shamt lives in the rs2 slot
						dec.imm = {27'b0, inInst.r.rs2};
						badCode = (funct7 != `RvF7Base);
					end
					default: badCode = 1'b1;
				endcase
			end
			`RvOpR: begin
				dec.unit = UnitAlu;
				dec.rs1 = gpr(inInst.r.rs1);
				dec.rs2 = gpr(inInst.r.rs2);
				dec.rd = gpr(inInst.r.rd);
				dec.command.alu.subOp.sub = funct7[5];
				dec.command.alu.subOp.arith = funct7[5];
				case (funct3)
					`RvF3Sll: dec.command.alu.op = AluShift;
					`RvF3Slt, `RvF3Sltu: begin
						dec.command.alu.op = AluComp;
						dec.command.alu.subOp.lessThan = 1'b1;
						dec.command.alu.subOp.isUnsigned = funct3[0];
					end
					`RvF3Xor: dec.command.alu.op = AluLogic;
					`RvF3SraSrl: begin
						dec.command.alu.op = AluShift;
						dec.command.alu.subOp.right = 1'b1;
					end
					`RvF3Or: begin
						dec.command.alu.op = AluLogic;
						dec.command.alu.subOp.logicSel = LogicOr;
					end
					`RvF3And: begin
						dec.command.alu.op = AluLogic;
						dec.command.alu.subOp.logicSel = LogicAnd;
					end
					default: dec.command.alu.op = AluAdd;
				endcase
				// only add/sub and the right shifts accept the alternate funct7
				if (funct7 == `RvF7Alt) begin
					badCode = (funct3 != `RvF3AddSub) && (funct3 != `RvF3SraSrl);
				end else begin
					badCode = (funct7 != `RvF7Base);
				end
			end
			`RvOpAuipc, `RvOpLui: begin
				dec.unit = UnitAlu;
				dec.rs1.regType = opcode[5] ? RegNone : RegPc;
				dec.rs2.regType = RegImm;
				dec.rd = gpr(inInst.u.rd);
				dec.imm = {inInst.u.imm, 12'b0};
			end
			// fence, system, atomics and fp go down as no-ops
			`RvOpMiscMem, `RvOpSystem, `RvOpAmo, `RvOpLoadFp, `RvOpStoreFp,
			`RvOpOpFp, `RvOpMadd, `RvOpMsub, `RvOpNmsub, `RvOpNmadd: begin
				dec.unit = UnitNop;
			end
			default: badCode = 1'b1;
		endcase
		dec.invalid = badCode;
		if (badCode) begin
			dec.unit = UnitNop;
		end
	end

	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			decValid <= 1'b0;
		end else if (inValid && inReady) begin
			decValid <= 1'b1;
		end else if (decReady) begin
			decValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			decEntry <= dec;
		end
	end

	decHold: assert property (@(posedge clk) disable iff (!reset_)
		decValid && !decReady |=> decValid && $stable(decEntry));

endmodule

`default_nettype wire

/* hdl/regFile.sv */
// general register file, x0 reads zero, two read ports and one write port
`timescale 1ns/10ps
`default_nettype none

module regFile import rvPkg::*; (
	input logic clk,
	input logic reset_,
	input RegAddr_t rdAddrA,
	input RegAddr_t rdAddrB,
	output logic [Xlen-1:0] rdDataA,
	output logic [Xlen-1:0] rdDataB,
	input logic wrEn,
	input RegAddr_t wrAddr,
	input logic [Xlen-1:0] wrData
);

	// x0 has no storage
	logic [Xlen-1:0] regs [1:31];

	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			for (int n = 1; n < 32; n++) begin
				regs[n] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

/* hdl/intExecute.sv */
// execute stage: operand read with bypass, ALU, branch compare, address and link, result register
`timescale 1ns/10ps
`default_nettype none

module intExecute import rvPkg::*; (
	input logic clk,
	input logic reset_,
	input logic decValid,
	output logic decReady,
	input DecEntry_t decEntry,
	output RegAddr_t rdAddrA,
	output RegAddr_t rdAddrB,
	input logic [Xlen-1:0] rdDataA,
	input logic [Xlen-1:0] rdDataB,
	input logic heldValid,
	input Result_t heldResult,
	output logic exeValid,
	input logic exeReady,
	output Result_t exeResult
);

	AluCmd_t alu;
	logic [Xlen-1:0] regA;
	logic [Xlen-1:0] regB;
	logic [Xlen-1:0] opA;
	logic [Xlen-1:0] opB;
	logic [Xlen-1:0] sum;
	logic [Xlen-1:0] shifted;
	logic [Xlen-1:0] logicOut;
	logic [Xlen-1:0] aluOut;
	logic [Xlen-1:0] pcImm;
	logic lessThan;
	logic compOut;
	Result_t res;

	// newest producer wins: own register, then the held result, then the file
	function automatic logic [Xlen-1:0] pickOperand(
		input RegAddr_t addr,
		input logic [Xlen-1:0] fileData,
		input logic newValid,
		input Result_t newRes,
		input logic oldValid,
		input Result_t oldRes
	);
		if (newValid && newRes.writeRd && newRes.rd == addr) begin
			return newRes.value;
		end
		if (oldValid && oldRes.writeRd && oldRes.rd == addr) begin
			return oldRes.value;
		end
		return fileData;
	endfunction

	assign alu = decEntry.command.alu;
	assign rdAddrA = decEntry.rs1.addr;
	assign rdAddrB = decEntry.rs2.addr;
	assign regA = pickOperand(rdAddrA, rdDataA, exeValid, exeResult, heldValid, heldResult);
	assign regB = pickOperand(rdAddrB, rdDataB, exeValid, exeResult, heldValid, heldResult);

	always_comb begin
		case (decEntry.rs1.regType)
			RegGpr: opA = regA;
			RegPc: opA = decEntry.pc;
			default: opA = '0;
		endcase
		case (decEntry.rs2.regType)
			RegGpr: opB = regB;
			RegImm: opB = decEntry.imm;
			default: opB = '0;
		endcase
	end

	// subtract as invert plus carry in
	assign sum = opA + (alu.subOp.sub ? ~opB : opB) + {{(Xlen-1){1'b0}}, alu.subOp.sub};
	assign lessThan = alu.subOp.isUnsigned ? (opA < opB) : ($signed(opA) < $signed(opB));
	// negate turns beq into bne and blt into bge
	assign compOut = (alu.subOp.lessThan ? lessThan : (opA == opB)) ^ alu.subOp.negate;
	assign pcImm = decEntry.pc + decEntry.imm;

	always_comb begin
		if (!alu.subOp.right) begin
			shifted = opA << opB[4:0];
		end else if (alu.subOp.arith) begin
			shifted = $signed(opA) >>> opB[4:0];
		end else begin
			shifted = opA >> opB[4:0];
		end
		case (alu.subOp.logicSel)
			LogicOr: logicOut = opA | opB;
			LogicAnd: logicOut = opA & opB;
			default: logicOut = opA ^ opB;
		endcase
		case (alu.op)
			AluComp: aluOut = {{(Xlen-1){1'b0}}, compOut};
			AluShift: aluOut = shifted;
			AluLogic: aluOut = logicOut;
			default: aluOut = sum;
		endcase
	end

	always_comb begin
		res = '0;
		res.pc = decEntry.pc;
		res.rd = decEntry.rd.addr;
		res.invalid = decEntry.invalid;
		res.memCmd = decEntry.command.mem;
		if (decEntry.unit == UnitAlu) begin
			// link value for jal and jalr
			res.value = alu.subOp.jump ? decEntry.pc + Xlen'(4) : aluOut;
			res.taken = alu.subOp.branch && compOut;
			if (alu.subOp.jump) begin
				res.target = {sum[Xlen-1:1], 1'b0};
			end else if (alu.subOp.branch) begin
				res.target = pcImm;
			end
			res.writeRd = !alu.subOp.branch && decEntry.rd.regType == RegGpr &&
				decEntry.rd.addr != '0;
		end
		if (decEntry.unit == UnitMem) begin
			res.memValid = 1'b1;
			res.memAddr = regA + decEntry.imm;
			if (decEntry.command.mem.op == MemStore) begin
				res.storeData = regB;
			end
		end
	end

	assign decReady = !exeValid || exeReady;

	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			exeValid <= 1'b0;
		end else if (decValid && decReady) begin
			exeValid <= 1'b1;
		end else if (exeReady) begin
			exeValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (decValid && decReady) begin
			exeResult <= res;
		end
	end

	exeHold: assert property (@(posedge clk) disable iff (!reset_)
		exeValid && !exeReady |=> exeValid && $stable(exeResult));

endmodule

`default_nettype wire

/* hdl/resultStage.sv */
// retiring result holder with output handshake and register writeback
`timescale 1ns/10ps
`default_nettype none

module resultStage import rvPkg::*; (
	input logic clk,
	input logic reset_,
	input logic exeValid,
	output logic exeReady,
	input Result_t exeResult,
	output logic outValid,
	input logic outReady,
	output Result_t outResult,
	output logic heldValid,
	output logic wrEn,
	output RegAddr_t wrAddr,
	output logic [Xlen-1:0] wrData
);

	assign exeReady = !outValid || outReady;
	assign heldValid = outValid;

	// file is written on the edge the consumer takes the record
	assign wrEn = outValid && outReady && outResult.writeRd;
	assign wrAddr = outResult.rd;
	assign wrData = outResult.value;

	always_ff @(posedge clk or negedge reset_) begin
		if (!reset_) begin
			outValid <= 1'b0;
		end else if (exeValid && exeReady) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (exeValid && exeReady) begin
			outResult <= exeResult;
		end
	end

	// a write only retires an accepted valid record and never targets x0
	wrOnAccept: assert property (@(posedge clk) disable iff (!reset_)
		wrEn |-> outValid && outReady && !outResult.invalid && wrAddr != '0);

endmodule

`default_nettype wire

/* hdl/rvCore.sv */
// RV32I core top: decoder, execute, result stage and register file
`timescale 1ns/10ps
`default_nettype none

module rvCore import rvPkg::*; (
	input logic clk,
	input logic reset_,
	input logic inValid,
	output logic inReady,
	input logic [Xlen-1:0] inPc,
	input RvInst_t inInst,
	output logic outValid,
	input logic outReady,
	output Result_t outResult
);

	logic decValid;
	logic decReady;
	DecEntry_t decEntry;
	logic exeValid;
	logic exeReady;
	Result_t exeResult;
	logic heldValid;
	logic wrEn;
	RegAddr_t wrAddr;
	logic [Xlen-1:0] wrData;
	RegAddr_t rdAddrA;
	RegAddr_t rdAddrB;
	logic [Xlen-1:0] rdDataA;
	logic [Xlen-1:0] rdDataB;

	instDecoder u_dec (.clk, .reset_, .inValid, .inReady, .inPc, .inInst,
		.decValid, .decReady, .decEntry);

	regFile u_regs (.clk, .reset_, .rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
		.wrEn, .wrAddr, .wrData);

	// the held record doubles as the older bypass source
	intExecute u_exe (.clk, .reset_, .decValid, .decReady, .decEntry,
		.rdAddrA, .rdAddrB, .rdDataA, .rdDataB, .heldValid, .heldResult(outResult),
		.exeValid, .exeReady, .exeResult);

	resultStage u_res (.clk, .reset_, .exeValid, .exeReady, .exeResult,
		.outValid, .outReady, .outResult, .heldValid, .wrEn, .wrAddr, .wrData);

endmodule

`default_nettype wire

/* tests/coreTb.sv */
// testbench for rvCore: encoders, ISA shadow model, directed tests, checker and timeout
`timescale 1ns/10ps
`default_nettype none

module coreTb import rvPkg::*; ();

	localparam logic [6:0] OpLui = 7'b0110111;
	localparam logic [6:0] OpAuipc = 7'b0010111;
	localparam logic [6:0] OpJal = 7'b1101111;
	localparam logic [6:0] OpJalr = 7'b1100111;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpLoad = 7'b0000011;
	localparam logic [6:0] OpStore = 7'b0100011;
	localparam logic [6:0] OpImm = 7'b0010011;
	localparam logic [6:0] OpR = 7'b0110011;
	// roughly 100 instructions and 250 cycles in all, so ten times that and more
	localparam int MaxCycles = 4000;

	logic clk;
	logic reset_;
	logic inValid;
	logic inReady;
	logic [31:0] inPc;
	RvInst_t inInst;
	logic outValid;
	logic outReady;
	Result_t outResult;

	logic [31:0] shadow [0:31];
	logic [31:0] instQ [$];
	Result_t expQ [$];
	Result_t gotQ [$];
	logic [31:0] nextPc;
	logic stall;
	string testName;
	integer seed;
	int errors;
	int checks;
	int testStart;
	int testsRun;
	int recIdx;
	int cycles = 0;

	rvCore u_dut (.clk, .reset_, .inValid, .inReady, .inPc, .inInst,
		.outValid, .outReady, .outResult);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MaxCycles) begin
			$display("timeout: the run did not finish within %0d cycles", MaxCycles);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OpR};
	endfunction

	function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OpStore};
	endfunction

	function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OpBranch};
	endfunction

	function automatic logic [31:0] encU(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OpJal};
	endfunction

	task automatic check(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s record %0d %s: expected %h actual %h",
				testName, recIdx, field, expected, actual);
		end
	endtask

	// ISA rules applied in program order against the shadow registers
	task automatic issue(input logic [31:0] w);
		Result_t e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [2:0] f3;
		logic wr;
		f3 = w[14:12];
		a = shadow[w[19:15]];
		b = shadow[w[24:20]];
		immI = {{20{w[31]}}, w[31:20]};
		immS = {{20{w[31]}}, w[31:25], w[11:7]};
		immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		e = '0;
		e.pc = nextPc;
		e.rd = w[11:7];
		wr = 1'b0;
		case (w[6:0])
			OpLui: begin
				wr = 1'b1;
				e.value = {w[31:12], 12'b0};
			end
			OpAuipc: begin
				wr = 1'b1;
				e.value = nextPc + {w[31:12], 12'b0};
			end
			OpJal: begin
				wr = 1'b1;
				e.value = nextPc + 32'd4;
				e.target = nextPc + immJ;
			end
			OpJalr: begin
				wr = 1'b1;
				e.value = nextPc + 32'd4;
				e.target = (a + immI) & ~32'd1;
			end
			OpBranch: begin
				e.target = nextPc + immB;
				case (f3)
					3'd0: e.taken = (a == b);
					3'd1: e.taken = (a != b);
					3'd4: e.taken = $signed(a) < $signed(b);
					3'd5: e.taken = $signed(a) >= $signed(b);
					3'd6: e.taken = a < b;
					3'd7: e.taken = a >= b;
					default: e.invalid = 1'b1;
				endcase
			end
			OpLoad, OpStore: begin
				e.memValid = 1'b1;
				e.memCmd.op = w[5] ? MemStore : MemLoad;
				e.memCmd.size = f3[1] ? MemWord : (f3[0] ? MemHalf : MemByte);
				e.memCmd.isUnsigned = f3[2];
				e.memAddr = a + (w[5] ? immS : immI);
				e.storeData = w[5] ? b : 32'd0;
			end
			OpImm: begin
				wr = 1'b1;
				if (f3 == 3'd0) begin
					e.value = a + immI;
				end else if (f3 == 3'd1 && w[31:25] == 7'h00) begin
					e.value = a << w[24:20];
				end else begin
					e.invalid = 1'b1;
				end
			end
			OpR: begin
				wr = 1'b1;
				case ({w[31:25], f3})
					{7'h00, 3'd0}: e.value = a + b;
					{7'h20, 3'd0}: e.value = a - b;
					{7'h00, 3'd1}: e.value = a << b[4:0];
					{7'h00, 3'd2}: e.value = {31'b0, $signed(a) < $signed(b)};
					{7'h00, 3'd3}: e.value = {31'b0, a < b};
					{7'h00, 3'd4}: e.value = a ^ b;
					{7'h00, 3'd5}: e.value = a >> b[4:0];
					{7'h20, 3'd5}: e.value = $signed(a) >>> b[4:0];
					{7'h00, 3'd6}: e.value = a | b;
					{7'h00, 3'd7}: e.value = a & b;
					default: e.invalid = 1'b1;
				endcase
			end
			default: e.invalid = 1'b1;
		endcase
		e.writeRd = wr && !e.invalid && e.rd != 5'd0;
		if (e.writeRd) begin
			shadow[e.rd] = e.value;
		end
		instQ.push_back(w);
		expQ.push_back(e);
		nextPc = nextPc + 32'd4;
	endtask

	task automatic sendAll();
		foreach (instQ[k]) begin
			@(negedge clk);
			inValid = 1'b1;
			inPc = expQ[k].pc;
			inInst = instQ[k];
			#5;
			while (!inReady) begin
				@(negedge clk);
				#5;
			end
			@(posedge clk);
		end
		@(negedge clk);
		inValid = 1'b0;
	endtask

	task automatic collect(input int n);
		logic [31:0] rnd;
		while (gotQ.size() < n) begin
			@(negedge clk);
			rnd = $random(seed);
			outReady = stall ? rnd[0] : 1'b1;
			#5;
			if (outValid && outReady) begin
				gotQ.push_back(outResult);
			end
			@(posedge clk);
		end
	endtask

	// sends the queued program, gathers the records and compares them
	task automatic runBatch(input logic backPressure);
		Result_t e;
		Result_t g;
		logic [6:0] op;
		int n;
		n = instQ.size();
		gotQ.delete();
		stall = backPressure;
		fork
			sendAll();
			collect(n);
		join
		repeat (4) begin
			@(negedge clk);
			outReady = 1'b1;
			#5;
			if (outValid) begin
				errors++;
				$display("%s: an output record arrived after the last expected one", testName);
			end
		end
		foreach (expQ[k]) begin
			e = expQ[k];
			g = gotQ[k];
			op = instQ[k][6:0];
			recIdx = k;
			check("pc", e.pc, g.pc);
			check("invalid", e.invalid, g.invalid);
			check("writeRd", e.writeRd, g.writeRd);
			check("taken", e.taken, g.taken);
			check("memValid", e.memValid, g.memValid);
			if (e.writeRd) begin
				check("rd", e.rd, g.rd);
				check("value", e.value, g.value);
			end
			if (op == OpJal || op == OpJalr || op == OpBranch) begin
				check("target", e.target, g.target);
			end
			if (e.memValid) begin
				check("memCmd", e.memCmd, g.memCmd);
				check("memAddr", e.memAddr, g.memAddr);
				check("storeData", e.storeData, g.storeData);
			end
		end
		$display("%s: %0d records, %0d errors", testName, n, errors - testStart);
		testsRun++;
		instQ.delete();
		expQ.delete();
	endtask

	task automatic startTest(input string name);
		testName = name;
		testStart = errors;
	endtask

	task automatic aluOps();
		logic [31:0] rnd;
		startTest("aluOps");
		for (int r = 1; r <= 4; r++) begin
			rnd = $random(seed);
			issue(encU(OpLui, 5'(r), rnd[31:12]));
			issue(encI(OpImm, 3'd0, 5'(r), 5'(r), rnd[11:0]));
		end
		issue(encR(7'h00, 3'd0, 5, 1, 2));
		issue(encR(7'h20, 3'd0, 6, 1, 2));
		issue(encR(7'h00, 3'd1, 7, 1, 3));
		issue(encR(7'h00, 3'd2, 8, 1, 2));
		issue(encR(7'h00, 3'd3, 9, 1, 2));
		issue(encR(7'h00, 3'd4, 10, 1, 2));
		issue(encR(7'h00, 3'd5, 11, 1, 3));
		issue(encR(7'h20, 3'd5, 12, 1, 3));
		issue(encR(7'h00, 3'd6, 13, 1, 2));
		issue(encR(7'h00, 3'd7, 14, 1, 2));
		issue(encR(7'h00, 3'd2, 15, 4, 2));
		issue(encI(OpImm, 3'd1, 16, 1, {7'h00, rnd[4:0]}));
		// write to x0 is dropped, the read after it must see zero
		issue(encR(7'h00, 3'd0, 0, 1, 2));
		issue(encR(7'h00, 3'd0, 17, 0, 0));
		runBatch(1'b0);
	endtask

	task automatic depChain();
		startTest("depChain");
		issue(encI(OpImm, 3'd0, 1, 0, 12'd37));
		issue(encR(7'h00, 3'd0, 2, 1, 1));
		issue(encR(7'h20, 3'd0, 3, 2, 1));
		issue(encR(7'h00, 3'd4, 4, 3, 2));
		issue(encI(OpImm, 3'd1, 5, 4, 12'd3));
		issue(encI(OpImm, 3'd0, 6, 5, 12'hff7));
		issue(encR(7'h00, 3'd6, 7, 6, 5));
		issue(encR(7'h00, 3'd0, 7, 7, 7));
		runBatch(1'b0);
	endtask

	task automatic jumps();
		logic [31:0] rnd;
		startTest("jumps");
		rnd = $random(seed);
		issue(encU(OpLui, 20, rnd[31:12]));
		rnd = $random(seed);
		issue(encU(OpAuipc, 21, rnd[31:12]));
		rnd = $random(seed);
		issue(encJ(1, {rnd[20:1], 1'b0}));
		issue(encI(OpJalr, 3'd0, 2, 20, rnd[11:0]));
		issue(encJ(3, 21'h1ffffc));
		// link of the previous jalr used as the base right away
		issue(encI(OpJalr, 3'd0, 4, 2, 12'h7ff));
		issue(encR(7'h00, 3'd0, 5, 1, 0));
		runBatch(1'b0);
	endtask

	task automatic branches();
		logic [2:0] brF3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		logic [4:0] lhs [3] = '{5'd1, 5'd3, 5'd4};
		logic [4:0] rhs [3] = '{5'd2, 5'd1, 5'd1};
		logic [31:0] rnd;
		startTest("branches");
		// equal pair, then -3 against 5, then 9 against 5
		issue(encI(OpImm, 3'd0, 1, 0, 12'd5));
		issue(encI(OpImm, 3'd0, 2, 0, 12'd5));
		issue(encI(OpImm, 3'd0, 3, 0, 12'hffd));
		issue(encI(OpImm, 3'd0, 4, 0, 12'd9));
		for (int f = 0; f < 6; f++) begin
			for (int p = 0; p < 3; p++) begin
				rnd = $random(seed);
				issue(encB(brF3[f], lhs[p], rhs[p], {rnd[12:1], 1'b0}));
			end
		end
		runBatch(1'b0);
	endtask

	task automatic memOps();
		logic [2:0] ldF3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		logic [31:0] rnd;
		startTest("memOps");
		rnd = $random(seed);
		issue(encU(OpLui, 5, rnd[31:12]));
		rnd = $random(seed);
		issue(encU(OpLui, 6, rnd[31:12]));
		issue(encI(OpImm, 3'd0, 6, 6, rnd[11:0]));
		issue(encI(OpImm, 3'd0, 7, 0, 12'd123));
		for (int k = 0; k < 5; k++) begin
			rnd = $random(seed);
			issue(encI(OpLoad, ldF3[k], 7, 5, rnd[11:0]));
		end
		for (int k = 0; k < 3; k++) begin
			rnd = $random(seed);
			issue(encS(3'(k), 5, 6, rnd[11:0]));
		end
		issue(encR(7'h00, 3'd0, 8, 7, 0));
		runBatch(1'b0);
	endtask

	task automatic invalidOps();
		logic [31:0] rnd;
		logic [6:0] f7;
		startTest("invalidOps");
		issue(encI(OpImm, 3'd0, 9, 0, 12'd77));
		issue({20'h00000, 5'd9, 7'b1111111});
		issue(encR(7'h01, 3'd0, 9, 1, 2));
		issue(encR(7'h00, 3'd0, 10, 9, 0));
		for (int k = 0; k < 20; k++) begin
			rnd = $random(seed);
			f7 = (rnd[3] && (rnd[2:0] == 3'd0 || rnd[2:0] == 3'd5)) ? 7'h20 : 7'h00;
			if (rnd[20:18] == 3'd0) begin
				f7 = 7'h01;
			end
			issue(encR(f7, rnd[2:0], {1'b0, rnd[7:4]}, {1'b0, rnd[11:8]},
				{1'b0, rnd[15:12]}));
		end
		runBatch(1'b1);
	endtask

	initial begin
		seed = 32'h3f201b6b;
		reset_ = 1'b0;
		inValid = 1'b0;
		inPc = '0;
		inInst = '0;
		outReady = 1'b1;
		stall = 1'b0;
		errors = 0;
		checks = 0;
		testsRun = 0;
		recIdx = 0;
		nextPc = 32'h0000_1000;
		for (int r = 0; r < 32; r++) begin
			shadow[r] = '0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_ = 1'b1;
		aluOps();
		depChain();
		jumps();
		branches();
		memOps();
		invalidOps();
		$display("%0d tests, %0d checks, %0d errors", testsRun, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hdl/rvPkg.sv
hdl/instDecoder.sv
hdl/regFile.sv
hdl/intExecute.sv
hdl/resultStage.sv
hdl/rvCore.sv
tests/coreTb.sv
